/* logic/buffer_cfg_pkg.sv */
// sizing for the capture buffer; CHANNELS and BANK_DEPTH must be powers of two, one bank per channel
package buffer_cfg_pkg;

  // input channels, also the number of memory banks
  localparam int CHANNELS     = 4;
  // bits per sample
  localparam int SAMPLE_WIDTH = 16;
  // samples held by one bank
  localparam int BANK_DEPTH   = 64;
  // register stages behind each bank read port
  localparam int READ_LATENCY = 2;

  // banking modes 0 .. log2(CHANNELS), mode m keeps 2^m channels
  localparam int MODE_COUNT   = $clog2(CHANNELS) + 1;
  localparam int MODE_WIDTH   = (MODE_COUNT > 1) ? $clog2(MODE_COUNT) : 1;

  // single active channel owns every bank
  localparam int TOTAL_DEPTH  = CHANNELS * BANK_DEPTH;
  // must reach TOTAL_DEPTH itself, hence the +1
  localparam int COUNT_WIDTH  = $clog2(TOTAL_DEPTH + 1);
  localparam int ADDR_WIDTH   = $clog2(BANK_DEPTH);

  // bank / channel select width
  localparam int CH_WIDTH     = (CHANNELS > 1) ? $clog2(CHANNELS) : 1;
  // upper index bits pick the bank segment
  localparam int SEG_WIDTH    = COUNT_WIDTH - ADDR_WIDTH;

endpackage

/* logic/buffer_types_pkg.sv */
// shared data types for the capture buffer; all widths follow buffer_cfg_pkg
package buffer_types_pkg;
  import buffer_cfg_pkg::*;

  // one sample from one channel
  typedef logic [SAMPLE_WIDTH-1:0] sample_t;

  // one sample per channel, channel 0 sits in the low bits
  typedef sample_t [CHANNELS-1:0] sample_vec_t;

  // per-channel sample count, 0 .. TOTAL_DEPTH
  typedef logic [COUNT_WIDTH-1:0] count_t;

  // mode m means 2^m active channels
  typedef logic [MODE_WIDTH-1:0] bank_mode_t;

  // capture sequence
  //   IDLE    -> waiting for arm, mode can be loaded
  //   ARMED   -> waiting for hw start
  //   SAVING  -> writing one vector per cycle
  //   HOLD    -> data kept, waiting for readout
  //   READOUT -> stream running
  typedef enum logic [2:0] {
    IDLE,
    ARMED,
    SAVING,
    HOLD,
    READOUT
  } capture_state_t;

endpackage

/* logic/capture_ctrl.sv */
// capture FSM on ps_clk; sw reset wins over start/stop in the same cycle, mode loads only in IDLE
module capture_ctrl
  import buffer_cfg_pkg::*, buffer_types_pkg::*;
(
  input  logic           ps_clk,
  input  logic           rst_n_i,
  input  bank_mode_t     bank_mode_i,
  input  logic           bank_mode_load_i,
  input  logic           arm_i,
  input  logic           hw_start_i,
  input  logic           hw_stop_i,
  input  logic           sw_reset_i,
  input  logic           readout_start_i,
  input  logic           readout_sw_reset_i,
  input  logic           rd_done_i,
  output capture_state_t state_o,
  output bank_mode_t     bank_mode_o,
  output logic           wr_en_o,
  output count_t         wr_index_o,
  output logic           armed_o,
  output logic           full_o,
  output count_t         depth_o,
  output logic           depth_valid_o,
  output logic           rd_go_o,
  output logic           rd_abort_o
);

  capture_state_t state_q;
  bank_mode_t     mode_q;
  count_t         count_q;
  count_t         capacity;
  logic           full_q;
  logic           depth_valid_q;
  logic           hit_full;

  // fewer channels share the banks, so each gets more depth
  assign capacity = count_t'(TOTAL_DEPTH >> mode_q);

  // stop cycle and reset cycle are not saved
  assign wr_en_o  = (state_q == SAVING) && !hw_stop_i && !sw_reset_i;
  // this write fills the last slot
  assign hit_full = wr_en_o && (count_q == capacity - count_t'(1));

  // readout pulses, capture reset also cancels a running stream
  assign rd_go_o    = (state_q == HOLD) && readout_start_i && !sw_reset_i;
  assign rd_abort_o = (state_q == READOUT) && (readout_sw_reset_i || sw_reset_i);

  always_ff @(posedge ps_clk) begin
    if (!rst_n_i) begin
      state_q       <= IDLE;
      mode_q        <= '0;
      count_q       <= '0;
      full_q        <= 1'b0;
      depth_valid_q <= 1'b0;
    end else begin
      // depth report is a single pulse
      depth_valid_q <= 1'b0;
      if (sw_reset_i) begin
        state_q <= IDLE;
        count_q <= '0;
        full_q  <= 1'b0;
      end else begin
        case (state_q)
          IDLE: begin
            // out-of-range modes clamp to the deepest sharing
            if (bank_mode_load_i) begin
              mode_q <= (bank_mode_i < MODE_COUNT) ? bank_mode_i : bank_mode_t'(MODE_COUNT - 1);
            end
            if (arm_i) begin
              state_q <= ARMED;
              full_q  <= 1'b0;
            end
          end
          ARMED: begin
            if (hw_start_i) begin
              state_q <= SAVING;
              count_q <= '0;
            end
          end
          SAVING: begin
            if (wr_en_o) begin
              count_q <= count_q + count_t'(1);
            end
            // hit_full is never set together with a stop
            if (hw_stop_i || hit_full) begin
              state_q       <= HOLD;
              depth_valid_q <= 1'b1;
              full_q        <= hit_full;
            end
          end
          HOLD: begin
            if (rd_go_o) begin
              state_q <= READOUT;
            end
          end
          READOUT: begin
            // abort keeps the data for another pass
            if (rd_abort_o) begin
              state_q <= HOLD;
            end else if (rd_done_i) begin
              state_q <= IDLE;
            end
          end
          default: state_q <= IDLE;
        endcase
      end
    end
  end

  assign state_o       = state_q;
  assign bank_mode_o   = mode_q;
  assign wr_index_o    = count_q;
  assign armed_o       = (state_q == ARMED);
  assign full_o        = full_q;
  // count stays put from HOLD until the next start
  assign depth_o       = count_q;
  assign depth_valid_o = depth_valid_q;

endmodule

/* logic/bank_writer.sv */
// combinational bank write mapping; index a of channel c goes to bank c + (a / BANK_DEPTH) * 2^m
module bank_writer
  import buffer_cfg_pkg::*, buffer_types_pkg::*;
(
  input  bank_mode_t                           bank_mode_i,
  input  logic                                 wr_en_i,
  input  count_t                               wr_index_i,
  input  sample_vec_t                          samples_i,
  output logic        [CHANNELS-1:0]           bank_we_o,
  output logic        [CHANNELS-1:0][ADDR_WIDTH-1:0] bank_addr_o,
  output sample_vec_t                          bank_data_o
);

  logic [CH_WIDTH-1:0]  lane_mask;
  logic [SEG_WIDTH-1:0] wr_seg;

  // low bank bits select the owning channel
  assign lane_mask = CH_WIDTH'((1 << bank_mode_i) - 1);

  // which bank segment the current index falls into
  assign wr_seg = wr_index_i[COUNT_WIDTH-1:ADDR_WIDTH];

  for (genvar b = 0; b < CHANNELS; b++) begin : g_bank
    logic [CH_WIDTH-1:0]  owner;
    logic [SEG_WIDTH-1:0] bank_seg;

    // bank b = owner + seg * 2^m
    assign owner    = CH_WIDTH'(b) & lane_mask;
    assign bank_seg = SEG_WIDTH'(b >> bank_mode_i);

    // only one segment per channel is live at a time
    assign bank_we_o[b]   = wr_en_i && (wr_seg == bank_seg);
    // offset inside the bank
    assign bank_addr_o[b] = wr_index_i[ADDR_WIDTH-1:0];
    // unused channels in low modes are simply not routed
    assign bank_data_o[b] = samples_i[owner];
  end

endmodule

/* logic/sample_bank.sv */
// one sample memory, no reset; read data appears READ_LATENCY enabled cycles after the address
module sample_bank
  import buffer_cfg_pkg::*, buffer_types_pkg::*;
(
  input  logic                  ps_clk,
  input  logic                  we_i,
  input  logic [ADDR_WIDTH-1:0] waddr_i,
  input  sample_t               wdata_i,
  input  logic                  re_i,
  input  logic [ADDR_WIDTH-1:0] raddr_i,
  output sample_t               rdata_o
);

  sample_t mem [BANK_DEPTH];
  // read pipeline, stage 0 is the array read
  sample_t rd_pipe [READ_LATENCY];

  // write port
  always_ff @(posedge ps_clk) begin
    if (we_i) begin
      mem[waddr_i] <= wdata_i;
    end
  end

  // whole read path holds while re_i is low
  always_ff @(posedge ps_clk) begin
    if (re_i) begin
      rd_pipe[0] <= mem[raddr_i];
      for (int i = 1; i < READ_LATENCY; i++) begin
        rd_pipe[i] <= rd_pipe[i-1];
      end
    end
  end

  assign rdata_o = rd_pipe[READ_LATENCY-1];

endmodule

/* logic/readout_ctrl.sv */
// readout stream; data and last stay steady under back-pressure, done pulses one cycle after last beat
module readout_ctrl
  import buffer_cfg_pkg::*, buffer_types_pkg::*;
(
  input  logic                  ps_clk,
  input  logic                  rst_n_i,
  input  bank_mode_t            bank_mode_i,
  input  count_t                depth_i,
  input  logic                  go_i,
  input  logic                  abort_i,
  output logic [ADDR_WIDTH-1:0] bank_raddr_o,
  output logic                  bank_re_o,
  input  sample_vec_t           bank_rdata_i,
  output sample_t               data_o,
  output logic                  valid_o,
  output logic                  last_o,
  input  logic                  ready_i,
  output logic                  done_o
);

  logic                active_q;
  logic [CH_WIDTH-1:0] ch_q;
  count_t              idx_q;
  logic                done_q;
  logic                vld_q  [READ_LATENCY];
  logic [CH_WIDTH-1:0] sel_q  [READ_LATENCY];
  logic                last_q [READ_LATENCY];
  logic [CH_WIDTH-1:0] last_ch;
  logic [CH_WIDTH-1:0] issue_bank;
  logic                issue_last;
  logic                end_of_ch;
  logic                advance;
  logic                issue;

  // highest active channel in this mode
  assign last_ch = CH_WIDTH'((1 << bank_mode_i) - 1);

  // the whole pipe stalls when the output beat is blocked
  assign advance = !(valid_o && !ready_i);
  assign issue   = active_q && advance;

  // same mapping as the write side
  assign issue_bank = ch_q + CH_WIDTH'(idx_q[COUNT_WIDTH-1:ADDR_WIDTH] << bank_mode_i);
  assign end_of_ch  = (idx_q == depth_i - count_t'(1));
  assign issue_last = end_of_ch && (ch_q == last_ch);

  // one address for all banks, the bank select picks the result
  assign bank_raddr_o = idx_q[ADDR_WIDTH-1:0];
  assign bank_re_o    = advance;

  // channel / index walk
  always_ff @(posedge ps_clk) begin
    if (!rst_n_i) begin
      active_q <= 1'b0;
      ch_q     <= '0;
      idx_q    <= '0;
      done_q   <= 1'b0;
    end else begin
      // an empty capture finishes at once
      done_q <= (valid_o && ready_i && last_o) || (go_i && (depth_i == '0));
      if (abort_i) begin
        active_q <= 1'b0;
      end else if (go_i) begin
        active_q <= (depth_i != '0);
        ch_q     <= '0;
        idx_q    <= '0;
      end else if (issue) begin
        if (end_of_ch) begin
          idx_q <= '0;
          ch_q  <= ch_q + 1'b1;
          if (ch_q == last_ch) begin
            active_q <= 1'b0;
          end
        end else begin
          idx_q <= idx_q + count_t'(1);
        end
      end
    end
  end

  // valid tags, matched to the bank read latency
  always_ff @(posedge ps_clk) begin
    if (!rst_n_i) begin
      for (int i = 0; i < READ_LATENCY; i++) begin
        vld_q[i] <= 1'b0;
      end
    end else if (abort_i) begin
      // flush, whatever is in flight is dropped
      for (int i = 0; i < READ_LATENCY; i++) begin
        vld_q[i] <= 1'b0;
      end
    end else if (advance) begin
      vld_q[0] <= issue;
      for (int i = 1; i < READ_LATENCY; i++) begin
        vld_q[i] <= vld_q[i-1];
      end
    end
  end

  // bank select and last tag ride alongside
  always_ff @(posedge ps_clk) begin
    if (advance) begin
      sel_q[0]  <= issue_bank;
      last_q[0] <= issue_last;
      for (int i = 1; i < READ_LATENCY; i++) begin
        sel_q[i]  <= sel_q[i-1];
        last_q[i] <= last_q[i-1];
      end
    end
  end

  assign valid_o = vld_q[READ_LATENCY-1];
  assign last_o  = valid_o && last_q[READ_LATENCY-1];
  assign data_o  = bank_rdata_i[sel_q[READ_LATENCY-1]];
  assign done_o  = done_q;

endmodule

/* logic/sample_buffer.sv */
// capture buffer top, single ps_clk domain; readout is ordered channel 0 first, last on final beat
module sample_buffer
  import buffer_cfg_pkg::*, buffer_types_pkg::*;
(
  input  logic        ps_clk,
  input  logic        rst_n_i,
  input  sample_vec_t samples_i,
  input  bank_mode_t  bank_mode_i,
  input  logic        bank_mode_load_i,
  input  logic        capture_arm_i,
  input  logic        capture_hw_start_i,
  input  logic        capture_hw_stop_i,
  input  logic        capture_sw_reset_i,
  input  logic        readout_start_i,
  input  logic        readout_sw_reset_i,
  input  logic        readout_ready_i,
  output logic        capture_armed_o,
  output logic        capture_full_o,
  output count_t      write_depth_o,
  output logic        write_depth_valid_o,
  output sample_t     readout_data_o,
  output logic        readout_valid_o,
  output logic        readout_last_o
);

  bank_mode_t                          bank_mode;
  logic                                wr_en;
  count_t                              wr_index;
  count_t                              depth;
  logic                                rd_go;
  logic                                rd_abort;
  logic                                rd_done;
  logic [CHANNELS-1:0]                 bank_we;
  logic [CHANNELS-1:0][ADDR_WIDTH-1:0] bank_waddr;
  sample_vec_t                         bank_wdata;
  logic                                bank_re;
  logic [ADDR_WIDTH-1:0]               bank_raddr;
  sample_vec_t                         bank_rdata;

  capture_ctrl i_capture_ctrl (
    .ps_clk             (ps_clk),
    .rst_n_i            (rst_n_i),
    .bank_mode_i        (bank_mode_i),
    .bank_mode_load_i   (bank_mode_load_i),
    .arm_i              (capture_arm_i),
    .hw_start_i         (capture_hw_start_i),
    .hw_stop_i          (capture_hw_stop_i),
    .sw_reset_i         (capture_sw_reset_i),
    .readout_start_i    (readout_start_i),
    .readout_sw_reset_i (readout_sw_reset_i),
    .rd_done_i          (rd_done),
    .state_o            (),
    .bank_mode_o        (bank_mode),
    .wr_en_o            (wr_en),
    .wr_index_o         (wr_index),
    .armed_o            (capture_armed_o),
    .full_o             (capture_full_o),
    .depth_o            (depth),
    .depth_valid_o      (write_depth_valid_o),
    .rd_go_o            (rd_go),
    .rd_abort_o         (rd_abort)
  );

  // depth report doubles as the readout length
  assign write_depth_o = depth;

  bank_writer i_bank_writer (
    .bank_mode_i (bank_mode),
    .wr_en_i     (wr_en),
    .wr_index_i  (wr_index),
    .samples_i   (samples_i),
    .bank_we_o   (bank_we),
    .bank_addr_o (bank_waddr),
    .bank_data_o (bank_wdata)
  );

  // one bank per channel, shared read address and enable
  for (genvar b = 0; b < CHANNELS; b++) begin : g_bank
    sample_bank i_sample_bank (
      .ps_clk  (ps_clk),
      .we_i    (bank_we[b]),
      .waddr_i (bank_waddr[b]),
      .wdata_i (bank_wdata[b]),
      .re_i    (bank_re),
      .raddr_i (bank_raddr),
      .rdata_o (bank_rdata[b])
    );
  end

  readout_ctrl i_readout_ctrl (
    .ps_clk       (ps_clk),
    .rst_n_i      (rst_n_i),
    .bank_mode_i  (bank_mode),
    .depth_i      (depth),
    .go_i         (rd_go),
    .abort_i      (rd_abort),
    .bank_raddr_o (bank_raddr),
    .bank_re_o    (bank_re),
    .bank_rdata_i (bank_rdata),
    .data_o       (readout_data_o),
    .valid_o      (readout_valid_o),
    .last_o       (readout_last_o),
    .ready_i      (readout_ready_i),
    .done_o       (rd_done)
  );

endmodule

/* verif/tb_clock_gen.sv */
// free-running ps_clk with a 40 ns period; reset is low over the first two rising edges only
module tb_clock_gen (
  output logic ps_clk,
  output logic rst_n_o
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int HALF_PERIOD_NS = 20;

  initial begin
    ps_clk = 1'b0;
    forever #(HALF_PERIOD_NS) ps_clk = ~ps_clk;
  end

  // release follows the input drive offset used by the testbench
  initial begin
    rst_n_o = 1'b0;
    repeat (2) @(posedge ps_clk);
    #2;
    rst_n_o = 1'b1;
  end

endmodule

/* verif/buffer_tb.sv */
// inputs move 2 ns after ps_clk rises and outputs are checked on the falling edge; modes 0..2 only
module buffer_tb
  import buffer_cfg_pkg::*, buffer_types_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  typedef sample_t sample_q_t[$];

  // strobe masks for tick()
  localparam logic [6:0] STB_LOAD   = 7'b000_0001;
  localparam logic [6:0] STB_ARM    = 7'b000_0010;
  localparam logic [6:0] STB_START  = 7'b000_0100;
  localparam logic [6:0] STB_STOP   = 7'b000_1000;
  localparam logic [6:0] STB_SWR    = 7'b001_0000;
  localparam logic [6:0] STB_RSTART = 7'b010_0000;
  localparam int         STB_RSWR_BIT = 6;
  localparam logic [6:0] STB_RSWR   = 7'b100_0000;

  // ready is low one cycle in four, so a full readout fits well inside this
  localparam int READOUT_LIMIT = 4 * TOTAL_DEPTH + 32;
  // capture and readout runs over all behaviors, each bounded by a full capture plus readout
  localparam int RUN_COUNT     = 20;
  localparam int WATCHDOG_NS   = RUN_COUNT * (TOTAL_DEPTH + READOUT_LIMIT + 64) * 40;

  logic           ps_clk;
  logic           rst_n;
  sample_vec_t    samples;
  bank_mode_t     bank_mode;
  logic           bank_mode_load;
  logic           capture_arm;
  logic           capture_hw_start;
  logic           capture_hw_stop;
  logic           capture_sw_reset;
  logic           readout_start;
  logic           readout_sw_reset;
  logic           readout_ready;
  logic           capture_armed;
  logic           capture_full;
  count_t         write_depth;
  logic           write_depth_valid;
  sample_t        readout_data;
  logic           readout_valid;
  logic           readout_last;

  // model state, updated when the inputs are driven
  capture_state_t m_state      = IDLE;
  bank_mode_t     m_mode       = '0;
  count_t         m_count      = '0;
  logic           m_full       = 1'b0;
  sample_vec_t    rec_q[$];
  sample_q_t      exp_q;
  logic           hold_entered = 1'b0;
  // model values that the DUT registers show during the current cycle
  capture_state_t seen_state   = IDLE;
  logic           seen_full    = 1'b0;
  count_t         seen_count   = '0;
  logic           depth_due    = 1'b0;
  // handshake bookkeeping from the falling-edge checker
  logic           last_taken   = 1'b0;
  logic           depth_seen   = 1'b0;
  logic           stalled      = 1'b0;
  sample_t        held_data;
  logic           held_last;
  bank_mode_t     next_mode;
  logic           ready_random;
  logic [31:0]    lcg_state    = 32'h81ac5e10;

  tb_clock_gen i_tb_clock_gen (
    .ps_clk  (ps_clk),
    .rst_n_o (rst_n)
  );

  sample_buffer i_sample_buffer (
    .ps_clk              (ps_clk),
    .rst_n_i             (rst_n),
    .samples_i           (samples),
    .bank_mode_i         (bank_mode),
    .bank_mode_load_i    (bank_mode_load),
    .capture_arm_i       (capture_arm),
    .capture_hw_start_i  (capture_hw_start),
    .capture_hw_stop_i   (capture_hw_stop),
    .capture_sw_reset_i  (capture_sw_reset),
    .readout_start_i     (readout_start),
    .readout_sw_reset_i  (readout_sw_reset),
    .readout_ready_i     (readout_ready),
    .capture_armed_o     (capture_armed),
    .capture_full_o      (capture_full),
    .write_depth_o       (write_depth),
    .write_depth_valid_o (write_depth_valid),
    .readout_data_o      (readout_data),
    .readout_valid_o     (readout_valid),
    .readout_last_o      (readout_last)
  );

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic int rand_range(input int lo, input int hi);
    return lo + int'(lcg_next() >> 8) % (hi - lo + 1);
  endfunction

  // high LCG bits, the low ones repeat too quickly
  function automatic sample_vec_t random_vec();
    sample_vec_t v;
    for (int c = 0; c < CHANNELS; c++) begin
      v[c] = sample_t'(lcg_next() >> 16);
    end
    return v;
  endfunction

  // channel 0 first, each channel in capture order
  function automatic sample_q_t expected_stream(input bank_mode_t mode, input sample_vec_t rec[$]);
    sample_q_t words;
    for (int c = 0; c < (1 << mode); c++) begin
      for (int a = 0; a < rec.size(); a++) begin
        words.push_back(rec[a][c]);
      end
    end
    return words;
  endfunction

  task automatic fail_run(input string line);
    $display("%s", line);
    $display("test failed");
    $fatal(1, "simulation stopped at %0t", $time);
  endtask

  task automatic check_sample(input string name, input sample_t got, input sample_t exp);
    if (got !== exp) begin
      fail_run($sformatf("MISMATCH %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_count(input string name, input count_t got, input count_t exp);
    if (got !== exp) begin
      fail_run($sformatf("MISMATCH %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      fail_run($sformatf("MISMATCH %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  // one clock of stimulus, model follows the capture rules with the same inputs
  task automatic tick(input logic [6:0] stb);
    logic [31:0] r;
    sample_vec_t vec;
    logic        done_now;
    @(posedge ps_clk);
    #2;
    vec          = random_vec();
    r            = lcg_next();
    seen_state   = m_state;
    seen_full    = m_full;
    seen_count   = m_count;
    depth_due    = hold_entered;
    hold_entered = 1'b0;
    done_now     = last_taken;
    last_taken   = 1'b0;
    samples          = vec;
    bank_mode        = next_mode;
    bank_mode_load   = |(stb & STB_LOAD);
    capture_arm      = |(stb & STB_ARM);
    capture_hw_start = |(stb & STB_START);
    capture_hw_stop  = |(stb & STB_STOP);
    capture_sw_reset = |(stb & STB_SWR);
    readout_start    = |(stb & STB_RSTART);
    readout_sw_reset = |(stb & STB_RSWR);
    // ready is held low in a readout reset cycle so no beat slips through the flush
    readout_ready    = (ready_random ? (r[31:30] != 2'b00) : 1'b1) && !stb[STB_RSWR_BIT];
    if (capture_sw_reset) begin
      m_state = IDLE;
      m_count = '0;
      m_full  = 1'b0;
      rec_q.delete();
      exp_q.delete();
    end else begin
      case (m_state)
        IDLE: begin
          if (bank_mode_load) begin
            m_mode = bank_mode;
          end
          if (capture_arm) begin
            m_state = ARMED;
            m_full  = 1'b0;
          end
        end
        ARMED: begin
          if (capture_hw_start) begin
            m_state = SAVING;
            m_count = '0;
            rec_q.delete();
          end
        end
        SAVING: begin
          // the stop cycle's vector is dropped
          if (capture_hw_stop) begin
            m_state      = HOLD;
            hold_entered = 1'b1;
          end else begin
            rec_q.push_back(vec);
            m_count = m_count + count_t'(1);
            if (m_count == count_t'(TOTAL_DEPTH >> m_mode)) begin
              m_state      = HOLD;
              m_full       = 1'b1;
              hold_entered = 1'b1;
            end
          end
        end
        HOLD: begin
          if (readout_start) begin
            m_state = READOUT;
            exp_q   = expected_stream(m_mode, rec_q);
          end
        end
        READOUT: begin
          if (readout_sw_reset) begin
            m_state = HOLD;
            exp_q.delete();
          end else if (done_now) begin
            m_state = IDLE;
          end
        end
      endcase
    end
  endtask

  task automatic wait_depth(input int limit);
    int n = 0;
    while (!depth_seen) begin
      if (n == limit) begin
        fail_run("ERROR: no write depth report arrived after the capture");
      end
      tick('0);
      n++;
    end
    depth_seen = 1'b0;
  endtask

  task automatic capture_until_stop(input bank_mode_t mode, input int len);
    next_mode  = mode;
    depth_seen = 1'b0;
    tick(STB_LOAD);
    tick(STB_ARM);
    tick(STB_START);
    repeat (len) tick('0);
    tick(STB_STOP);
    wait_depth(4);
  endtask

  task automatic capture_until_full(input bank_mode_t mode);
    next_mode  = mode;
    depth_seen = 1'b0;
    tick(STB_LOAD);
    tick(STB_ARM);
    tick(STB_START);
    wait_depth(TOTAL_DEPTH + 4);
    check_count("write_depth_o", write_depth, count_t'(TOTAL_DEPTH >> mode));
    check_flag("capture_full_o", capture_full, 1'b1);
  endtask

  // start the stream and wait for the model to see the last beat taken
  task automatic run_readout();
    int n = 0;
    tick(STB_RSTART);
    while (m_state == READOUT) begin
      if (n == READOUT_LIMIT) begin
        fail_run("ERROR: readout stream did not finish");
      end
      tick('0);
      n++;
    end
    if (exp_q.size() != 0) begin
      fail_run("ERROR: readout ended with beats still missing");
    end
  endtask

  // comparing process, all outputs are settled at the falling edge
  always @(negedge ps_clk) begin
    if (rst_n) begin
      check_flag("capture_armed_o", capture_armed, seen_state == ARMED);
      check_flag("capture_full_o", capture_full, seen_full);
      check_flag("write_depth_valid_o", write_depth_valid, depth_due);
      if (write_depth_valid) begin
        check_count("write_depth_o", write_depth, seen_count);
        depth_seen = 1'b1;
      end
      if (readout_valid && seen_state != READOUT) begin
        fail_run("ERROR: readout_valid_o is high while no readout is running");
      end
      // a blocked beat must come back unchanged
      if (stalled && seen_state == READOUT) begin
        check_flag("readout_valid_o", readout_valid, 1'b1);
        check_sample("readout_data_o", readout_data, held_data);
        check_flag("readout_last_o", readout_last, held_last);
      end
      if (readout_valid && readout_ready) begin
        if (exp_q.size() == 0) begin
          fail_run("ERROR: readout beat arrived past the end of the stream");
        end
        check_sample("readout_data_o", readout_data, exp_q[0]);
        check_flag("readout_last_o", readout_last, exp_q.size() == 1);
        if (exp_q.size() == 1) begin
          last_taken = 1'b1;
        end
        void'(exp_q.pop_front());
      end
      stalled   = readout_valid && !readout_ready;
      held_data = readout_data;
      held_last = readout_last;
    end
  end

  initial begin
    #(WATCHDOG_NS);
    fail_run("ERROR: watchdog expired before the tests finished");
  end

  initial begin
    samples          = '0;
    bank_mode        = '0;
    bank_mode_load   = 1'b0;
    capture_arm      = 1'b0;
    capture_hw_start = 1'b0;
    capture_hw_stop  = 1'b0;
    capture_sw_reset = 1'b0;
    readout_start    = 1'b0;
    readout_sw_reset = 1'b0;
    readout_ready    = 1'b1;
    next_mode        = '0;
    ready_random     = 1'b0;
    wait (rst_n === 1'b1);
    // stopped captures in every mode, full stays low
    for (int m = 0; m < MODE_COUNT; m++) begin
      capture_until_stop(bank_mode_t'(m), rand_range(20, 50));
      check_flag("capture_full_o", capture_full, 1'b0);
      run_readout();
    end
    // memory filled in every mode, read back under back-pressure
    ready_random = 1'b1;
    for (int m = 0; m < MODE_COUNT; m++) begin
      capture_until_full(bank_mode_t'(m));
      run_readout();
    end
    // start without arm, stop and readout start outside their states
    tick(STB_START);
    tick(STB_STOP);
    tick(STB_ARM);
    tick(STB_STOP);
    tick(STB_RSTART);
    tick(STB_SWR);
    tick(STB_RSTART);
    repeat (8) tick('0);
    // capture reset in ARMED, in SAVING together with a stop, then in HOLD
    tick(STB_ARM);
    tick(STB_SWR);
    tick(STB_ARM);
    tick(STB_START);
    repeat (rand_range(5, 15)) tick('0);
    tick(STB_SWR | STB_STOP);
    repeat (4) tick('0);
    capture_until_stop(bank_mode_t'(1), rand_range(20, 50));
    tick(STB_SWR);
    repeat (4) tick('0);
    capture_until_stop(bank_mode_t'(1), rand_range(20, 50));
    run_readout();
    // readout reset, ignored in HOLD, then aborting a running stream
    capture_until_stop(bank_mode_t'(2), rand_range(20, 50));
    tick(STB_RSWR);
    tick(STB_STOP);
    tick(STB_RSTART);
    repeat (rand_range(6, 20)) tick('0);
    tick(STB_RSWR);
    repeat (4) tick('0);
    run_readout();
    repeat (4) tick('0);
    $display("test passed");
    $finish;
  end

endmodule

/* sim.f */
logic/buffer_cfg_pkg.sv
logic/buffer_types_pkg.sv
logic/capture_ctrl.sv
logic/bank_writer.sv
logic/sample_bank.sv
logic/readout_ctrl.sv
logic/sample_buffer.sv
verif/tb_clock_gen.sv
verif/buffer_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run with Verilator, a $fatal in the testbench gives a non-zero exit status
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/100ps -Wno-fatal \
  --top-module buffer_tb -f sim.f -o buffer_sim \
  && ./obj_dir/buffer_sim \
  || exit 1
